//--- verilog/sta_pkg.sv
`default_nettype none

package sta_pkg;

  // ========================================
  // Tile shape
  // ========================================
  localparam int ROWS      = 4;
  localparam int COLS      = 4;
  localparam int TOTAL_PES = ROWS * COLS;

  // Largest matrix dimension and the coordinate width that covers it
  localparam int MAX_N     = 64;
  localparam int N_BITS    = $clog2(MAX_N);

  // ========================================
  // Datapath widths
  // ========================================
  localparam int OP_BITS   = 8;
  // Room for 64 signed int8 products plus headroom
  localparam int ACC_BITS  = 24;
  // Step count from 1 to MAX_N needs one bit more than a coordinate
  localparam int K_BITS    = N_BITS + 1;

  typedef logic signed [OP_BITS-1:0]  operand_t;
  typedef logic signed [ACC_BITS-1:0] acc_t;
  // Coordinates wrap modulo MAX_N
  typedef logic [N_BITS-1:0]          coord_t;
  typedef logic [K_BITS-1:0]          klen_t;

  // Element i of a column feeds grid row i
  typedef operand_t [ROWS-1:0]      a_col_t;
  // Element j of a row feeds grid column j
  typedef operand_t [COLS-1:0]      b_row_t;
  // Flat PE index is i*COLS + j
  typedef acc_t     [TOTAL_PES-1:0] acc_grid_t;
  typedef coord_t   [TOTAL_PES-1:0] coord_vec_t;

  // One tagged result on the output stream
  typedef struct packed {
    coord_t row;
    coord_t col;
    acc_t   value;
  } result_t;

  typedef enum logic [1:0] {S_IDLE, S_CLEAR, S_COMPUTE, S_DRAIN} seq_state_t;

endpackage

`default_nettype wire

//--- verilog/tile_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tile_sequencer (
  input  logic               clk
  ,input  logic              reset
  ,input  logic              stall
  ,input  logic              start
  ,input  sta_pkg::klen_t    k_len
  ,input  sta_pkg::coord_t   pos_row
  ,input  sta_pkg::coord_t   pos_col
  // Final compute step from the step counter
  ,input  logic              last
  ,input  logic              coord_idle
  ,input  logic              draining
  ,output logic              clear
  ,output logic              feed
  ,output logic              done
  ,output logic              busy
  ,output sta_pkg::klen_t    steps
  ,output sta_pkg::coord_t   base_row
  ,output sta_pkg::coord_t   base_col
);

  sta_pkg::seq_state_t state;
  sta_pkg::seq_state_t state_next;

  // ========================================
  // Phase FSM
  // ========================================
  always_comb begin
    state_next = state;
    case (state)
      sta_pkg::S_IDLE:    if (start) state_next = sta_pkg::S_CLEAR;
      // One cycle to zero the grid and re-arm the coordinator
      sta_pkg::S_CLEAR:   state_next = sta_pkg::S_COMPUTE;
      sta_pkg::S_COMPUTE: if (last) state_next = sta_pkg::S_DRAIN;
      // Wait for the coordinator to fire and the packer to empty
      sta_pkg::S_DRAIN:   if (coord_idle && !draining) state_next = sta_pkg::S_IDLE;
      default:            state_next = sta_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sta_pkg::S_IDLE;
    end else if (!stall) begin
      state <= state_next;
    end
  end

  // Tile settings held for the whole run
  always_ff @(posedge clk) begin
    if (!stall && state == sta_pkg::S_IDLE && start) begin
      steps    <= k_len;
      base_row <= pos_row;
      base_col <= pos_col;
    end
  end

  // Phase decodes
  assign clear = (state == sta_pkg::S_CLEAR);
  assign feed  = (state == sta_pkg::S_COMPUTE);
  assign done  = (state == sta_pkg::S_DRAIN);
  assign busy  = (state != sta_pkg::S_IDLE);

endmodule

`default_nettype wire

//--- verilog/step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module step_counter (
  input  logic             clk
  ,input  logic            reset
  ,input  logic            stall
  ,input  logic            clear
  ,input  logic            feed
  ,input  sta_pkg::klen_t  steps
  ,output logic            last
);

  // Steps already taken in this tile
  sta_pkg::klen_t count;
  sta_pkg::klen_t count_inc;
  // Zero steps runs as a single step
  sta_pkg::klen_t eff_steps;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (!stall) begin
      if (clear) begin
        count <= '0;
      end else if (feed) begin
        count <= count_inc;
      end
    end
  end

  assign count_inc = count + sta_pkg::klen_t'(1);
  assign eff_steps = (steps == '0) ? sta_pkg::klen_t'(1) : steps;
  // High during the step that completes the run
  assign last      = (count_inc == eff_steps);

endmodule

`default_nettype wire

//--- verilog/pe_grid.sv
`timescale 1ns/1ps
`default_nettype none

module pe_grid (
  input  logic                clk
  ,input  logic               reset
  ,input  logic               stall
  ,input  logic               clear
  ,input  logic               feed
  ,input  sta_pkg::a_col_t    a_col
  ,input  sta_pkg::b_row_t    b_row
  ,output sta_pkg::acc_grid_t acc
  ,output logic               sta_idle
);

  // ========================================
  // MAC array
  // ========================================
  for (genvar i = 0; i < sta_pkg::ROWS; i++) begin : g_row
    for (genvar j = 0; j < sta_pkg::COLS; j++) begin : g_col
      sta_pkg::acc_t prod;

      // Sign extend both operands before the multiply
      assign prod = sta_pkg::acc_t'(a_col[i]) * sta_pkg::acc_t'(b_row[j]);

      always_ff @(posedge clk) begin
        if (!stall) begin
          if (clear) begin
            acc[i*sta_pkg::COLS + j] <= '0;
          end else if (feed) begin
            acc[i*sta_pkg::COLS + j] <= acc[i*sta_pkg::COLS + j] + prod;
          end
        end
      end
    end
  end

  // ========================================
  // Idle report
  // ========================================
  // Goes high one edge after the last feed cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      sta_idle <= 1'b1;
    end else if (!stall) begin
      sta_idle <= !feed;
    end
  end

endmodule

`default_nettype wire

//--- verilog/output_coordinator.sv
`timescale 1ns/1ps
`default_nettype none

module output_coordinator (
  input  logic                 clk
  ,input  logic                reset
  ,input  logic                stall
  // Re-arms the one-shot for a new tile
  ,input  logic                clear
  ,input  logic                done
  ,input  logic                sta_idle
  ,input  sta_pkg::coord_t     pos_row
  ,input  sta_pkg::coord_t     pos_col
  ,output logic                idle
  ,output logic                out_valid
  ,output sta_pkg::coord_vec_t out_row
  ,output sta_pkg::coord_vec_t out_col
);

  // High for the single cycle of the output pulse
  logic valid_state;
  // Set once fired, blocks a second pulse on the same data
  logic fired;

  // ========================================
  // One-shot valid FSM
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_state <= 1'b0;
      fired       <= 1'b0;
    end else if (!stall) begin
      if (clear) begin
        valid_state <= 1'b0;
        fired       <= 1'b0;
      end else if (done && sta_idle && !valid_state && !fired) begin
        // Run finished and array quiet
        valid_state <= 1'b1;
        fired       <= 1'b1;
      end else if (valid_state) begin
        valid_state <= 1'b0;
      end
    end
  end

  assign out_valid = valid_state;
  // Fired and the pulse is over
  assign idle      = fired && !valid_state;

  // ========================================
  // Absolute coordinates per PE
  // ========================================
  // Base plus PE offset, wraps modulo MAX_N
  always_comb begin
    for (int i = 0; i < sta_pkg::ROWS; i++) begin
      for (int j = 0; j < sta_pkg::COLS; j++) begin
        out_row[i*sta_pkg::COLS + j] = pos_row + sta_pkg::coord_t'(i);
        out_col[i*sta_pkg::COLS + j] = pos_col + sta_pkg::coord_t'(j);
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/result_packer.sv
`timescale 1ns/1ps
`default_nettype none

module result_packer (
  input  logic                 clk
  ,input  logic                reset
  ,input  logic                stall
  ,input  logic                out_valid
  ,input  sta_pkg::acc_grid_t  acc
  ,input  sta_pkg::coord_vec_t out_row
  ,input  sta_pkg::coord_vec_t out_col
  ,output logic                draining
  ,output logic                res_valid
  ,output sta_pkg::result_t    res
);

  // Holding copy of the grid, taken on the valid pulse
  sta_pkg::acc_grid_t  hold_acc;
  sta_pkg::coord_vec_t hold_row;
  sta_pkg::coord_vec_t hold_col;
  // Next PE to send, row-major
  logic [$clog2(sta_pkg::TOTAL_PES)-1:0] idx;
  logic                                  valid_q;

  // ========================================
  // Control
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      draining <= 1'b0;
      valid_q  <= 1'b0;
      idx      <= '0;
    end else if (!stall) begin
      if (out_valid) begin
        // Element 0 goes straight out, the rest from the copy
        draining <= 1'b1;
        valid_q  <= 1'b1;
        idx      <= 1;
      end else if (draining) begin
        valid_q  <= 1'b1;
        idx      <= idx + 1'b1;
        draining <= (idx != sta_pkg::TOTAL_PES - 1);
      end else begin
        valid_q  <= 1'b0;
      end
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (!stall) begin
      if (out_valid) begin
        hold_acc <= acc;
        hold_row <= out_row;
        hold_col <= out_col;
        res      <= '{row: out_row[0], col: out_col[0], value: acc[0]};
      end else if (draining) begin
        res      <= '{row: hold_row[idx], col: hold_col[idx], value: hold_acc[idx]};
      end
    end
  end

  // A held result counts once, on its first unstalled cycle
  assign res_valid = valid_q && !stall;

endmodule

`default_nettype wire

//--- verilog/sta_tile_top.sv
`timescale 1ns/1ps
`default_nettype none

module sta_tile_top (
  input  logic               clk
  ,input  logic              reset
  ,input  logic              stall
  ,input  logic              start
  ,input  sta_pkg::klen_t    k_len
  ,input  sta_pkg::coord_t   pos_row
  ,input  sta_pkg::coord_t   pos_col
  ,input  sta_pkg::a_col_t   a_col
  ,input  sta_pkg::b_row_t   b_row
  ,output logic              busy
  ,output logic              feed
  ,output logic              res_valid
  ,output sta_pkg::result_t  res
);

  // ========================================
  // Internal links
  // ========================================
  logic                clear;
  logic                done;
  logic                last;
  logic                coord_idle;
  logic                draining;
  logic                sta_idle;
  logic                out_valid;
  sta_pkg::klen_t      steps;
  sta_pkg::coord_t     base_row;
  sta_pkg::coord_t     base_col;
  sta_pkg::acc_grid_t  acc;
  sta_pkg::coord_vec_t out_row;
  sta_pkg::coord_vec_t out_col;

  tile_sequencer i_seq (
    .clk, .reset, .stall, .start, .k_len, .pos_row, .pos_col,
    .last, .coord_idle, .draining,
    .clear, .feed, .done, .busy, .steps, .base_row, .base_col
  );

  step_counter i_steps (.clk, .reset, .stall, .clear, .feed, .steps, .last);

  pe_grid i_grid (.clk, .reset, .stall, .clear, .feed, .a_col, .b_row, .acc, .sta_idle);

  // Coordinator sees the latched tile base
  output_coordinator i_coord (
    .clk, .reset, .stall, .clear, .done, .sta_idle,
    .pos_row(base_row), .pos_col(base_col),
    .idle(coord_idle), .out_valid, .out_row, .out_col
  );

  result_packer i_pack (
    .clk, .reset, .stall, .out_valid, .acc, .out_row, .out_col,
    .draining, .res_valid, .res
  );

endmodule

`default_nettype wire

//--- tb/sta_tile_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sta_tile_tb;

  localparam int NUM_TESTS   = 8;
  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 5;
  localparam logic [31:0] LFSR_SEED = 32'h47ea_bd4d;

  logic                 clk;
  logic                 reset;
  logic                 stall;
  logic                 start;
  sta_pkg::klen_t       k_len;
  sta_pkg::coord_t      pos_row;
  sta_pkg::coord_t      pos_col;
  sta_pkg::a_col_t      a_col;
  sta_pkg::b_row_t      b_row;
  logic                 busy;
  logic                 feed;
  logic                 res_valid;
  sta_pkg::result_t     res;

  // Test table with one row per tile
  string      test_name [NUM_TESTS];
  int         test_klen [NUM_TESTS];
  int         test_row  [NUM_TESTS];
  int         test_col  [NUM_TESTS];
  // Stall on cycle c when bit c mod 8 is set
  logic [7:0] test_mask [NUM_TESTS];
  logic       table_ready;

  logic [31:0] lfsr;
  int          error_count;
  int          fail_count;
  // Reference accumulators by flat index i*COLS + j
  int          exp_acc [sta_pkg::TOTAL_PES];

  sta_tile_top i_dut (
    .clk, .reset, .stall, .start, .k_len, .pos_row, .pos_col,
    .a_col, .b_row, .busy, .feed, .res_valid, .res
  );

  // ========================================
  // Helpers
  // ========================================
  task automatic add_test(input int t, input string name, input int klen, input int row,
                          input int col, input logic [7:0] mask);
    test_name[t] = name;
    test_klen[t] = klen;
    test_row[t]  = row;
    test_col[t]  = col;
    test_mask[t] = mask;
  endtask

  task automatic load_table();
    add_test(0, "basic",        4,  0,  0,  8'h00);
    add_test(1, "single_step",  1,  8,  12, 8'h00);
    add_test(2, "full_depth",   64, 16, 32, 8'h00);
    // Base near the top edge makes coordinates wrap
    add_test(3, "wrap_base",    5,  62, 61, 8'h00);
    add_test(4, "stall_sparse", 7,  4,  60, 8'b0000_0101);
    add_test(5, "stall_dense",  64, 62, 62, 8'b0110_1001);
    // k_len of zero runs one step
    add_test(6, "zero_klen",    0,  1,  2,  8'b1000_0000);
    add_test(7, "back_to_back", 2,  40, 44, 8'h00);
    table_ready = 1'b1;
  endtask

  // Galois LFSR shifting right with taps 32 31 29 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hD000_0001;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit
  task automatic draw_byte(output logic [7:0] v);
    int b;
    v = '0;
    for (b = 0; b < 8; b++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string test, input string field,
                             input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    if (expected !== actual) begin
      $display("error: %s %s expected %0d actual %0d", test, field, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_failure(input string test, input string what);
    $display("%s: %s", test, what);
    error_count++;
  endtask

  // ========================================
  // One tile from start until busy falls
  // ========================================
  task automatic run_tile(input int t);
    int               cyc;
    int               n_res;
    int               n_feed;
    int               errors_before;
    int               eff_k;
    int               i;
    int               j;
    logic             started;
    logic             finished;
    logic             prev_stall;
    logic [7:0]       byte_val;
    sta_pkg::result_t prev_res;
    for (i = 0; i < sta_pkg::TOTAL_PES; i++) begin
      exp_acc[i] = 0;
    end
    eff_k         = (test_klen[t] == 0) ? 1 : test_klen[t];
    errors_before = error_count;
    cyc           = 0;
    n_res         = 0;
    n_feed        = 0;
    started       = 1'b0;
    finished      = 1'b0;
    prev_stall    = 1'b0;
    prev_res      = res;
    while (!finished) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      // busy already shows whether this edge took the start
      if (!started && busy) begin
        started = 1'b1;
      end
      start = !started;
      stall = test_mask[t][cyc % 8];
      if (!started) begin
        k_len   = sta_pkg::klen_t'(test_klen[t]);
        pos_row = sta_pkg::coord_t'(test_row[t]);
        pos_col = sta_pkg::coord_t'(test_col[t]);
      end else begin
        // Scrambled settings must not reach the running tile
        k_len   = sta_pkg::klen_t'(test_klen[t] + 3);
        pos_row = sta_pkg::coord_t'(test_row[t] + 17);
        pos_col = sta_pkg::coord_t'(test_col[t] + 9);
      end
      if (feed) begin
        for (i = 0; i < sta_pkg::ROWS; i++) begin
          draw_byte(byte_val);
          a_col[i] = byte_val;
        end
        for (j = 0; j < sta_pkg::COLS; j++) begin
          draw_byte(byte_val);
          b_row[j] = byte_val;
        end
        // Only an unstalled edge takes the operands
        if (!stall) begin
          n_feed++;
          for (i = 0; i < sta_pkg::ROWS; i++) begin
            for (j = 0; j < sta_pkg::COLS; j++) begin
              exp_acc[i*sta_pkg::COLS + j] += $signed(a_col[i]) * $signed(b_row[j]);
            end
          end
        end
      end
      // Sample mid cycle where outputs are settled
      @(negedge clk);
      if (res_valid) begin
        if (stall) report_failure(test_name[t], "result valid during a stalled cycle");
        if (!busy) report_failure(test_name[t], "result valid while busy is low");
        if (n_res >= sta_pkg::TOTAL_PES) begin
          report_failure(test_name[t], "extra result after the sixteenth");
        end else begin
          i = n_res / sta_pkg::COLS;
          j = n_res % sta_pkg::COLS;
          check_value(test_name[t], "row", (test_row[t] + i) % sta_pkg::MAX_N, res.row);
          check_value(test_name[t], "col", (test_col[t] + j) % sta_pkg::MAX_N, res.col);
          check_value(test_name[t], "value", exp_acc[n_res], int'(res.value));
        end
        n_res++;
      end
      // Edge after a stalled cycle leaves the payload alone
      if (prev_stall && res !== prev_res) begin
        report_failure(test_name[t], "result changed across a stalled cycle");
      end
      prev_stall = stall;
      prev_res   = res;
      if (started && !busy) begin
        finished = 1'b1;
      end
      cyc++;
    end
    if (n_res < sta_pkg::TOTAL_PES) begin
      report_failure(test_name[t], $sformatf("missing results, got %0d of 16", n_res));
    end
    check_value(test_name[t], "feed cycles", eff_k, n_feed);
    if (error_count != errors_before) begin
      fail_count++;
    end
    $display("test %-13s %s  results %0d  feed cycles %0d  cycles %0d", test_name[t],
             (error_count == errors_before) ? "passed" : "failed", n_res, n_feed, cyc);
  endtask

  // ========================================
  // Clock and main sequence
  // ========================================
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    int t;
    reset       = 1'b1;
    stall       = 1'b0;
    start       = 1'b0;
    k_len       = '0;
    pos_row     = '0;
    pos_col     = '0;
    a_col       = '0;
    b_row       = '0;
    lfsr        = LFSR_SEED;
    error_count = 0;
    fail_count  = 0;
    load_table();
    repeat (3) @(posedge clk);
    #(DRIVE_DELAY);
    reset = 1'b0;
    @(negedge clk);
    check_value("after_reset", "busy", 0, busy);
    check_value("after_reset", "feed", 0, feed);
    check_value("after_reset", "res_valid", 0, res_valid);
    // tiles follow each other with no gap
    for (t = 0; t < NUM_TESTS; t++) begin
      run_tile(t);
    end
    // Quiet period with stall released so a stray result would show
    @(posedge clk);
    #(DRIVE_DELAY);
    stall = 1'b0;
    repeat (4) begin
      @(negedge clk);
      if (res_valid) report_failure("idle", "result valid with no tile running");
    end
    $display("tests %0d  passed %0d  failed %0d  errors %0d",
             NUM_TESTS, NUM_TESTS - fail_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog limit is twice the table length plus setup per tile
  initial begin
    int limit;
    int t;
    wait (table_ready === 1'b1);
    limit = 0;
    for (t = 0; t < NUM_TESTS; t++) begin
      limit += (test_klen[t] + 40) * 2;
    end
    repeat (limit) @(posedge clk);
    $display("watchdog: run did not finish within %0d clock cycles", limit);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
verilog/sta_pkg.sv
verilog/tile_sequencer.sv
verilog/step_counter.sv
verilog/pe_grid.sv
verilog/output_coordinator.sv
verilog/result_packer.sv
verilog/sta_tile_top.sv
tb/sta_tile_tb.sv

//--- Bender.yml
package:
  name: sta_tile

dependencies: {}

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - verilog/sta_pkg.sv
      - verilog/tile_sequencer.sv
      - verilog/step_counter.sv
      - verilog/pe_grid.sv
      - verilog/output_coordinator.sv
      - verilog/result_packer.sv
      - verilog/sta_tile_top.sv
  - target: test
    files:
      - tb/sta_tile_tb.sv
